/* source/SmaSelector_cfg.svh */
// SMA selector configuration
// Register map, reset select words, version and status mask

`ifndef SMA_SELECTOR_CFG_SVH
`define SMA_SELECTOR_CFG_SVH

// **************************************************
// Register addresses
// **************************************************

// Input select words of connectors 1/2 and 3/4
`define SMA_ADDR_IN_SEL12   16'h0000
`define SMA_ADDR_IN_SEL34   16'h0004

// Output select words of connectors 1/2 and 3/4
`define SMA_ADDR_OUT_SEL12  16'h0008
`define SMA_ADDR_OUT_SEL34  16'h000C

`define SMA_ADDR_VERSION    16'h0010
`define SMA_ADDR_STATUS     16'h2000

// **************************************************
// Reset select words
// **************************************************

// Bit 15 enables the connector buffer, bits 14:0 hold the code
`define SMA_IN1_RST         16'h8000
`define SMA_IN2_RST         16'h8001
`define SMA_IN3_RST         16'h0000
`define SMA_IN4_RST         16'h0000

`define SMA_OUT1_RST        16'h0000
`define SMA_OUT2_RST        16'h0000
`define SMA_OUT3_RST        16'h8000
`define SMA_OUT4_RST        16'h8001

// **************************************************
// Identification and status
// **************************************************

`define SMA_VERSION         32'h0001_0001

// Enable and level bit of each connector, two bits per nibble
`define SMA_STATUS_MASK     32'h0000_3333

`endif

/* source/SmaSelectorPkg.sv */
// SMA selector types
// Enums and packed structs shared by the register bank, muxes and top level

`default_nettype none

package SmaSelectorPkg;

  // AXI4-Lite access state
  typedef enum logic [1:0] {
    Idle  = 2'd0,
    Read  = 2'd1,
    Write = 2'd2,
    Resp  = 2'd3
  } AxiState_t;

  typedef enum logic [1:0] {
    Okay   = 2'd0,
    SlvErr = 2'd2
  } AxiResp_t;

  // Output source codes, one hot except the 10 MHz reference
  typedef enum logic [14:0] {
    SrcRef10MHz   = 15'h0000,
    SrcFpgaPps    = 15'h0001,
    SrcMacPps     = 15'h0002,
    SrcGnss1Pps   = 15'h0004,
    SrcGnss2Pps   = 15'h0008,
    SrcIrigMaster = 15'h0010,
    SrcDcfMaster  = 15'h0020,
    SrcSigGen1    = 15'h0040,
    SrcSigGen2    = 15'h0080,
    SrcSigGen3    = 15'h0100,
    SrcSigGen4    = 15'h0200,
    SrcUartGnss1  = 15'h0400,
    SrcUartGnss2  = 15'h0800,
    SrcUartExt    = 15'h1000,
    SrcGnd        = 15'h2000,
    SrcVcc        = 15'h4000
  } OutSrc_t;

  // Bit index of each input destination in an input code
  typedef enum logic [3:0] {
    DstExtPps1, DstExtPps2, DstTs1, DstTs2, DstIrigSlave, DstDcfSlave, DstTs3,
    DstTs4, DstFreqCnt1, DstFreqCnt2, DstFreqCnt3, DstFreqCnt4, DstUartExt
  } InDest_t;

  typedef struct packed {
    logic        Enable;
    logic [14:0] Code;
  } SmaSel_t;

  // Index 0 is connector 1
  typedef struct packed {
    SmaSel_t [3:0] In;
    SmaSel_t [3:0] Out;
  } SmaCfg_t;

  typedef struct packed {
    logic UartExt, UartGnss2, UartGnss1;
    logic SigGen4, SigGen3, SigGen2, SigGen1;
    logic DcfMaster, IrigMaster;
    logic Gnss2Pps, Gnss1Pps, MacPps, FpgaPps;
  } SmaSources_t;

  // LSB first matches InDest_t, so bit d is destination d
  typedef struct packed {
    logic UartExt, FreqCnt4, FreqCnt3, FreqCnt2, FreqCnt1, Ts4, Ts3;
    logic DcfSlave, IrigSlave, Ts2, Ts1, ExtPps2, ExtPps1;
  } SmaDests_t;

  typedef struct packed {
    logic        AwValid;
    logic [15:0] AwAddr;
    logic        WValid;
    logic [31:0] WData;
    logic        BReady;
    logic        ArValid;
    logic [15:0] ArAddr;
    logic        RReady;
  } AxiReq_t;

  typedef struct packed {
    logic        AwReady;
    logic        WReady;
    logic        BValid;
    AxiResp_t    BResp;
    logic        ArReady;
    logic        RValid;
    AxiResp_t    RResp;
    logic [31:0] RData;
  } AxiRsp_t;

endpackage

`default_nettype wire

/* source/SmaRegBank.sv */
// SMA selector register bank
// AXI4-Lite slave holding the select words, version and sampled input status

`default_nettype none

`include "SmaSelector_cfg.svh"

module SmaRegBank (
  input  wire                          SysClk_ClkIn,
  input  wire                          SysRstN_RstIn,
  input  wire SmaSelectorPkg::AxiReq_t AxiReq,
  output SmaSelectorPkg::AxiRsp_t      AxiRsp,
  input  wire [3:0]                    SmaIn,
  output SmaSelectorPkg::SmaCfg_t      Cfg
);

  SmaSelectorPkg::AxiState_t state;

  logic awReady;
  logic wReady;
  logic bValid;
  logic arReady;
  logic rValid;

  SmaSelectorPkg::AxiResp_t bResp;
  SmaSelectorPkg::AxiResp_t rResp;
  logic [31:0]              rData;

  // Select words, lower connector in bits 15:0
  logic [31:0] inSel12;
  logic [31:0] inSel34;
  logic [31:0] outSel12;
  logic [31:0] outSel34;

  logic [31:0] statusReg;
  logic [31:0] statusNext;

  logic                     wrHs;
  logic                     rdHs;
  SmaSelectorPkg::AxiResp_t wrResp;
  SmaSelectorPkg::AxiResp_t rdResp;
  logic [31:0]              rdData;

  // **************************************************
  // Handshake FSM
  // **************************************************

  assign wrHs = (state == SmaSelectorPkg::Write) && AxiReq.AwValid && awReady &&
                AxiReq.WValid && wReady;
  assign rdHs = (state == SmaSelectorPkg::Read) && AxiReq.ArValid && arReady;

  always_ff @(posedge SysClk_ClkIn or posedge SysRstN_RstIn) begin
    if (SysRstN_RstIn) begin
      state   <= SmaSelectorPkg::Idle;
      awReady <= 1'b0;
      wReady  <= 1'b0;
      bValid  <= 1'b0;
      arReady <= 1'b0;
      rValid  <= 1'b0;
    end else begin
      case (state)
        SmaSelectorPkg::Idle: begin
          // Write wins when both are requested
          if (AxiReq.AwValid && AxiReq.WValid) begin
            awReady <= 1'b1;
            wReady  <= 1'b1;
            state   <= SmaSelectorPkg::Write;
          end else if (AxiReq.ArValid) begin
            arReady <= 1'b1;
            state   <= SmaSelectorPkg::Read;
          end
        end
        SmaSelectorPkg::Write: begin
          if (wrHs) begin
            awReady <= 1'b0;
            wReady  <= 1'b0;
            bValid  <= 1'b1;
            state   <= SmaSelectorPkg::Resp;
          end
        end
        SmaSelectorPkg::Read: begin
          if (rdHs) begin
            arReady <= 1'b0;
            rValid  <= 1'b1;
            state   <= SmaSelectorPkg::Resp;
          end
        end
        SmaSelectorPkg::Resp: begin
          // Nothing new is accepted until the response is taken
          if (bValid && AxiReq.BReady) begin
            bValid <= 1'b0;
            state  <= SmaSelectorPkg::Idle;
          end else if (rValid && AxiReq.RReady) begin
            rValid <= 1'b0;
            state  <= SmaSelectorPkg::Idle;
          end
        end
        default: state <= SmaSelectorPkg::Idle;
      endcase
    end
  end

  // **************************************************
  // Address decode
  // **************************************************

  // Only the select words are writable
  always_comb begin
    case (AxiReq.AwAddr)
      `SMA_ADDR_IN_SEL12, `SMA_ADDR_IN_SEL34,
      `SMA_ADDR_OUT_SEL12, `SMA_ADDR_OUT_SEL34: wrResp = SmaSelectorPkg::Okay;
      default:                                  wrResp = SmaSelectorPkg::SlvErr;
    endcase
  end

  always_comb begin
    rdResp = SmaSelectorPkg::Okay;
    case (AxiReq.ArAddr)
      `SMA_ADDR_IN_SEL12:  rdData = inSel12;
      `SMA_ADDR_IN_SEL34:  rdData = inSel34;
      `SMA_ADDR_OUT_SEL12: rdData = outSel12;
      `SMA_ADDR_OUT_SEL34: rdData = outSel34;
      `SMA_ADDR_VERSION:   rdData = `SMA_VERSION;
      `SMA_ADDR_STATUS:    rdData = statusReg;
      default: begin
        rdData = '0;
        rdResp = SmaSelectorPkg::SlvErr;
      end
    endcase
  end

  // Response payload, loaded on the handshake edge
  always_ff @(posedge SysClk_ClkIn) begin
    if (wrHs) begin
      bResp <= wrResp;
    end
    if (rdHs) begin
      rData <= rdData;
      rResp <= rdResp;
    end
  end

  // **************************************************
  // Select words and status
  // **************************************************

  always_ff @(posedge SysClk_ClkIn or posedge SysRstN_RstIn) begin
    if (SysRstN_RstIn) begin
      inSel12  <= {`SMA_IN2_RST, `SMA_IN1_RST};
      inSel34  <= {`SMA_IN4_RST, `SMA_IN3_RST};
      outSel12 <= {`SMA_OUT2_RST, `SMA_OUT1_RST};
      outSel34 <= {`SMA_OUT4_RST, `SMA_OUT3_RST};
    end else if (wrHs) begin
      case (AxiReq.AwAddr)
        `SMA_ADDR_IN_SEL12:  inSel12  <= AxiReq.WData;
        `SMA_ADDR_IN_SEL34:  inSel34  <= AxiReq.WData;
        `SMA_ADDR_OUT_SEL12: outSel12 <= AxiReq.WData;
        `SMA_ADDR_OUT_SEL34: outSel34 <= AxiReq.WData;
        default: ;
      endcase
    end
  end

  // Per connector: bit 4k is the input enable, bit 4k+1 the pin level
  always_comb begin
    statusNext = '0;
    for (int k = 0; k < 4; k++) begin
      statusNext[4*k]   = Cfg.In[k].Enable;
      statusNext[4*k+1] = SmaIn[k];
    end
  end

  always_ff @(posedge SysClk_ClkIn or posedge SysRstN_RstIn) begin
    if (SysRstN_RstIn) begin
      statusReg <= '0;
    end else begin
      statusReg <= statusNext & `SMA_STATUS_MASK;
    end
  end

  assign Cfg.In  = {inSel34, inSel12};
  assign Cfg.Out = {outSel34, outSel12};

  assign AxiRsp = '{
    AwReady: awReady,
    WReady:  wReady,
    BValid:  bValid,
    BResp:   bResp,
    ArReady: arReady,
    RValid:  rValid,
    RResp:   rResp,
    RData:   rData
  };

endmodule

`default_nettype wire

/* source/SmaInputDemux.sv */
// SMA input demultiplexer
// Routes connector inputs to internal destinations and flags the 10 MHz input

`default_nettype none

module SmaInputDemux (
  input  wire                          SysClk_ClkIn,
  input  wire                          SysRstN_RstIn,
  input  wire SmaSelectorPkg::SmaCfg_t Cfg,
  input  wire [3:0]                    SmaIn,
  output SmaSelectorPkg::SmaDests_t    Dests,
  output logic [3:0]                   SmaInEn,
  output logic                         Ref10MHzEn
);

  logic [12:0] destVec;

  // Lowest connector wins, so scan from connector 4 down to connector 1
  always_comb begin
    for (int d = 0; d <= int'(SmaSelectorPkg::DstUartExt); d++) begin
      destVec[d] = 1'b0;
      for (int k = 3; k >= 0; k--) begin
        if (Cfg.In[k].Code[d]) begin
          destVec[d] = SmaIn[k];
        end
      end
    end
  end

  assign Dests = destVec;

  // Buffer enables
  always_comb begin
    for (int k = 0; k < 4; k++) begin
      SmaInEn[k] = Cfg.In[k].Enable;
    end
  end

  // **************************************************
  // 10 MHz reference input
  // **************************************************

  // Only connector 1 carries the external 10 MHz, selected by code 0
  always_ff @(posedge SysClk_ClkIn or posedge SysRstN_RstIn) begin
    if (SysRstN_RstIn) begin
      Ref10MHzEn <= 1'b0;
    end else begin
      Ref10MHzEn <= (Cfg.In[0].Code == '0);
    end
  end

endmodule

`default_nettype wire

/* source/SmaOutputMux.sv */
// SMA output multiplexer
// Picks the source of each connector from its output select code

`default_nettype none

module SmaOutputMux (
  input  wire SmaSelectorPkg::SmaCfg_t     Cfg,
  input  wire SmaSelectorPkg::SmaSources_t Sources,
  input  wire                              Ref10MHz,
  output logic [3:0]                       SmaOut,
  output logic [3:0]                       SmaOutEn
);

  always_comb begin
    for (int k = 0; k < 4; k++) begin
      SmaOutEn[k] = Cfg.Out[k].Enable;
      case (Cfg.Out[k].Code)
        SmaSelectorPkg::SrcRef10MHz:   SmaOut[k] = Ref10MHz;
        SmaSelectorPkg::SrcFpgaPps:    SmaOut[k] = Sources.FpgaPps;
        SmaSelectorPkg::SrcMacPps:     SmaOut[k] = Sources.MacPps;
        SmaSelectorPkg::SrcGnss1Pps:   SmaOut[k] = Sources.Gnss1Pps;
        SmaSelectorPkg::SrcGnss2Pps:   SmaOut[k] = Sources.Gnss2Pps;
        SmaSelectorPkg::SrcIrigMaster: SmaOut[k] = Sources.IrigMaster;
        SmaSelectorPkg::SrcDcfMaster:  SmaOut[k] = Sources.DcfMaster;
        SmaSelectorPkg::SrcSigGen1:    SmaOut[k] = Sources.SigGen1;
        SmaSelectorPkg::SrcSigGen2:    SmaOut[k] = Sources.SigGen2;
        SmaSelectorPkg::SrcSigGen3:    SmaOut[k] = Sources.SigGen3;
        SmaSelectorPkg::SrcSigGen4:    SmaOut[k] = Sources.SigGen4;
        SmaSelectorPkg::SrcUartGnss1:  SmaOut[k] = Sources.UartGnss1;
        SmaSelectorPkg::SrcUartGnss2:  SmaOut[k] = Sources.UartGnss2;
        SmaSelectorPkg::SrcUartExt:    SmaOut[k] = Sources.UartExt;
        SmaSelectorPkg::SrcGnd:        SmaOut[k] = 1'b0;
        SmaSelectorPkg::SrcVcc:        SmaOut[k] = 1'b1;
        // Unknown code: 10 MHz on connectors 1 and 3, FPGA PPS on 2 and 4
        default: begin
          if (k % 2 == 0) begin
            SmaOut[k] = Ref10MHz;
          end else begin
            SmaOut[k] = Sources.FpgaPps;
          end
        end
      endcase
    end
  end

endmodule

`default_nettype wire

/* source/SmaSelector.sv */
// SMA connector selector top level
// Register bank plus input demux and output mux for the four SMA connectors

`default_nettype none

module SmaSelector (
  input  wire                              SysClk_ClkIn,
  input  wire                              SysRstN_RstIn,
  // AXI4-Lite slave
  input  wire SmaSelectorPkg::AxiReq_t     AxiReq,
  output wire SmaSelectorPkg::AxiRsp_t     AxiRsp,
  // Connector pins and buffer enables
  input  wire [3:0]                        SmaIn,
  output wire [3:0]                        SmaOut,
  output wire [3:0]                        SmaInEn,
  output wire [3:0]                        SmaOutEn,
  // Internal sources and destinations
  input  wire SmaSelectorPkg::SmaSources_t Sources,
  input  wire                              Ref10MHz,
  output wire SmaSelectorPkg::SmaDests_t   Dests,
  output wire                              Ref10MHzEn
);

  SmaSelectorPkg::SmaCfg_t cfg;

  SmaRegBank regBank_i (
    .SysClk_ClkIn  (SysClk_ClkIn),
    .SysRstN_RstIn (SysRstN_RstIn),
    .AxiReq        (AxiReq),
    .AxiRsp        (AxiRsp),
    .SmaIn         (SmaIn),
    .Cfg           (cfg)
  );

  SmaInputDemux inputDemux_i (
    .SysClk_ClkIn  (SysClk_ClkIn),
    .SysRstN_RstIn (SysRstN_RstIn),
    .Cfg           (cfg),
    .SmaIn         (SmaIn),
    .Dests         (Dests),
    .SmaInEn       (SmaInEn),
    .Ref10MHzEn    (Ref10MHzEn)
  );

  SmaOutputMux outputMux_i (
    .Cfg      (cfg),
    .Sources  (Sources),
    .Ref10MHz (Ref10MHz),
    .SmaOut   (SmaOut),
    .SmaOutEn (SmaOutEn)
  );

endmodule

`default_nettype wire

/* tb/SmaSelectorTb.sv */
// SMA selector testbench
// Directed tests of register access, muxing, status and back-pressure

`default_nettype none

`include "SmaSelector_cfg.svh"

module SmaSelectorTb;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int ClkPeriod      = 40;
  localparam int ResetCycles    = 16;
  localparam int HandshakeLimit = 16;
  // Bus transactions over all tests, their length and the cycles spent outside them
  localparam int TxnCount       = 90;
  localparam int TxnCycles      = 6;
  localparam int IdleCycles     = 150;
  localparam int WatchdogCycles = 2 * (ResetCycles + TxnCount * TxnCycles + IdleCycles);

  localparam int FlagAwReady = 0;
  localparam int FlagWReady  = 1;
  localparam int FlagBValid  = 2;
  localparam int FlagArReady = 3;
  localparam int FlagRValid  = 4;

  logic                        SysClk_ClkIn;
  logic                        SysRstN_RstIn;
  SmaSelectorPkg::AxiReq_t     axiReq;
  SmaSelectorPkg::AxiRsp_t     axiRsp;
  logic [3:0]                  smaIn;
  logic [3:0]                  smaOut;
  logic [3:0]                  smaInEn;
  logic [3:0]                  smaOutEn;
  SmaSelectorPkg::SmaSources_t sources;
  logic                        ref10MHz;
  SmaSelectorPkg::SmaDests_t   dests;
  logic                        ref10MHzEn;

  logic [31:0] rngState;
  int          errorCount;
  int          checkCount;

  SmaSelector dut_i (
    .SysClk_ClkIn  (SysClk_ClkIn),
    .SysRstN_RstIn (SysRstN_RstIn),
    .AxiReq        (axiReq),
    .AxiRsp        (axiRsp),
    .SmaIn         (smaIn),
    .SmaOut        (smaOut),
    .SmaInEn       (smaInEn),
    .SmaOutEn      (smaOutEn),
    .Sources       (sources),
    .Ref10MHz      (ref10MHz),
    .Dests         (dests),
    .Ref10MHzEn    (ref10MHzEn)
  );

  always #(ClkPeriod / 2) SysClk_ClkIn = ~SysClk_ClkIn;

  initial begin
    #(WatchdogCycles * ClkPeriod);
    $display("Watchdog timeout: the tests did not finish within %0d cycles", WatchdogCycles);
    $display("Test failed");
    $finish;
  end

  // **************************************************
  // Helpers and compare tasks
  // **************************************************

  function automatic logic [31:0] nextRandom();
    logic [31:0] x;
    x = rngState;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rngState = x;
    return x;
  endfunction

  function automatic logic [15:0] selAddress(input int idx);
    case (idx)
      0:       return `SMA_ADDR_IN_SEL12;
      1:       return `SMA_ADDR_IN_SEL34;
      2:       return `SMA_ADDR_OUT_SEL12;
      default: return `SMA_ADDR_OUT_SEL34;
    endcase
  endfunction

  task automatic compareWord(input string testName, input logic [31:0] expected,
                             input logic [31:0] actual);
    checkCount++;
    if (actual !== expected) begin
      errorCount++;
      $display("[ERROR] %s: expected %h, actual %h", testName, expected, actual);
    end
  endtask

  task automatic compareResp(input string testName, input SmaSelectorPkg::AxiResp_t expected,
                             input SmaSelectorPkg::AxiResp_t actual);
    checkCount++;
    if (actual !== expected) begin
      errorCount++;
      $display("[ERROR] %s: expected %s (%0d), actual %s (%0d)", testName,
               expected.name(), expected, actual.name(), actual);
    end
  endtask

  task automatic compareBit(input string testName, input logic expected, input logic actual);
    checkCount++;
    if (actual !== expected) begin
      errorCount++;
      $display("[ERROR] %s: expected %b, actual %b", testName, expected, actual);
    end
  endtask

  // **************************************************
  // AXI4-Lite master
  // **************************************************

  function automatic logic rspFlag(input int flagSel);
    case (flagSel)
      FlagAwReady: return axiRsp.AwReady;
      FlagWReady:  return axiRsp.WReady;
      FlagBValid:  return axiRsp.BValid;
      FlagArReady: return axiRsp.ArReady;
      default:     return axiRsp.RValid;
    endcase
  endfunction

  // Polls on falling edges, where the registered flags are stable
  task automatic awaitFlag(input int flagSel, input string what, output bit seen);
    int waitCount;
    waitCount = 0;
    while (!rspFlag(flagSel) && waitCount < HandshakeLimit) begin
      @(negedge SysClk_ClkIn);
      waitCount++;
    end
    seen = rspFlag(flagSel);
    if (!seen) begin
      errorCount++;
      $display("Timeout: %s did not arrive within %0d cycles", what, HandshakeLimit);
    end
  endtask

  task automatic writeRequest(input logic [15:0] addr, input logic [31:0] data,
                              output bit accepted);
    bit seen;
    axiReq.AwAddr  = addr;
    axiReq.WData   = data;
    axiReq.AwValid = 1'b1;
    axiReq.WValid  = 1'b1;
    awaitFlag(FlagAwReady, "write address ready", seen);
    if (seen) begin
      awaitFlag(FlagWReady, "write data ready", seen);
    end
    // Handshake edge lies before the next falling edge
    if (seen) begin
      @(negedge SysClk_ClkIn);
    end
    axiReq.AwValid = 1'b0;
    axiReq.WValid  = 1'b0;
    if (seen) begin
      awaitFlag(FlagBValid, "write response valid", seen);
    end
    accepted = seen;
  endtask

  task automatic writeResponse(output SmaSelectorPkg::AxiResp_t resp);
    resp = axiRsp.BResp;
    axiReq.BReady = 1'b1;
    @(negedge SysClk_ClkIn);
    axiReq.BReady = 1'b0;
  endtask

  task automatic busWrite(input logic [15:0] addr, input logic [31:0] data,
                          output SmaSelectorPkg::AxiResp_t resp);
    bit accepted;
    writeRequest(addr, data, accepted);
    if (accepted) begin
      writeResponse(resp);
    end else begin
      resp = SmaSelectorPkg::SlvErr;
    end
  endtask

  task automatic busRead(input logic [15:0] addr, output logic [31:0] data,
                         output SmaSelectorPkg::AxiResp_t resp);
    bit seen;
    data = '0;
    resp = SmaSelectorPkg::SlvErr;
    axiReq.ArAddr  = addr;
    axiReq.ArValid = 1'b1;
    awaitFlag(FlagArReady, "read address ready", seen);
    if (seen) begin
      @(negedge SysClk_ClkIn);
    end
    axiReq.ArValid = 1'b0;
    if (seen) begin
      awaitFlag(FlagRValid, "read data valid", seen);
    end
    if (seen) begin
      data = axiRsp.RData;
      resp = axiRsp.RResp;
      axiReq.RReady = 1'b1;
      @(negedge SysClk_ClkIn);
      axiReq.RReady = 1'b0;
    end
  endtask

  task automatic checkedWrite(input string testName, input logic [15:0] addr,
                              input logic [31:0] data);
    SmaSelectorPkg::AxiResp_t resp;
    busWrite(addr, data, resp);
    compareResp(testName, SmaSelectorPkg::Okay, resp);
  endtask

  task automatic checkedRead(input string testName, input logic [15:0] addr,
                             input logic [31:0] expected,
                             input SmaSelectorPkg::AxiResp_t expResp);
    logic [31:0]              data;
    SmaSelectorPkg::AxiResp_t resp;
    busRead(addr, data, resp);
    compareResp(testName, expResp, resp);
    compareWord(testName, expected, data);
  endtask

  // Lower connector of each pair sits in bits 15:0
  task automatic writeSelects(input string testName, input bit outputs,
                              input logic [3:0][14:0] codes, input logic [3:0] enables);
    checkedWrite(testName, outputs ? `SMA_ADDR_OUT_SEL12 : `SMA_ADDR_IN_SEL12,
                 {enables[1], codes[1], enables[0], codes[0]});
    checkedWrite(testName, outputs ? `SMA_ADDR_OUT_SEL34 : `SMA_ADDR_IN_SEL34,
                 {enables[3], codes[3], enables[2], codes[2]});
  endtask

  // **************************************************
  // Reference models
  // **************************************************

  // Zero is the 10 MHz reference, a single set bit b picks source b, Gnd and Vcc are constants
  function automatic logic expectedOut(input logic [14:0] code, input int conn,
                                       input logic [12:0] srcBits, input logic refClk);
    logic result;
    result = 1'b0;
    if (code == 15'd0) begin
      result = refClk;
    end else if ($countones(code) != 1) begin
      result = (conn % 2 == 0) ? refClk : srcBits[0];
    end else if (code[13]) begin
      result = 1'b0;
    end else if (code[14]) begin
      result = 1'b1;
    end else begin
      for (int b = 0; b < 13; b++) begin
        if (code[b]) begin
          result = srcBits[b];
        end
      end
    end
    return result;
  endfunction

  function automatic logic [12:0] expectedDests(input logic [3:0][14:0] codes,
                                                input logic [3:0] pins);
    logic [12:0] result;
    bit          found;
    result = '0;
    for (int d = 0; d < 13; d++) begin
      found = 1'b0;
      for (int k = 0; k < 4; k++) begin
        if (!found && codes[k][d]) begin
          result[d] = pins[k];
          found = 1'b1;
        end
      end
    end
    return result;
  endfunction

  // **************************************************
  // Directed tests
  // **************************************************

  task automatic resetDefaultsTest();
    logic [3:0][15:0] inRst;
    logic [3:0][15:0] outRst;
    logic [3:0][31:0] expWords;
    inRst    = {`SMA_IN4_RST, `SMA_IN3_RST, `SMA_IN2_RST, `SMA_IN1_RST};
    outRst   = {`SMA_OUT4_RST, `SMA_OUT3_RST, `SMA_OUT2_RST, `SMA_OUT1_RST};
    expWords = {outRst[3:2], outRst[1:0], inRst[3:2], inRst[1:0]};
    for (int i = 0; i < 4; i++) begin
      checkedRead("reset defaults", selAddress(i), expWords[i], SmaSelectorPkg::Okay);
    end
    checkedRead("reset defaults", `SMA_ADDR_VERSION, `SMA_VERSION, SmaSelectorPkg::Okay);
    for (int k = 0; k < 4; k++) begin
      compareBit("reset defaults", inRst[k][15], smaInEn[k]);
      compareBit("reset defaults", outRst[k][15], smaOutEn[k]);
    end
    compareBit("reset defaults", 1'b1, ref10MHzEn);
  endtask

  task automatic registerAccessTest();
    logic [31:0]              shadow [4];
    SmaSelectorPkg::AxiResp_t resp;
    for (int i = 0; i < 4; i++) begin
      shadow[i] = nextRandom();
      checkedWrite("register access", selAddress(i), shadow[i]);
    end
    for (int i = 0; i < 4; i++) begin
      checkedRead("register access", selAddress(i), shadow[i], SmaSelectorPkg::Okay);
    end
    // Version, status and a hole in the map are not writable
    busWrite(`SMA_ADDR_VERSION, nextRandom(), resp);
    compareResp("register access", SmaSelectorPkg::SlvErr, resp);
    busWrite(`SMA_ADDR_STATUS, nextRandom(), resp);
    compareResp("register access", SmaSelectorPkg::SlvErr, resp);
    busWrite(16'h0014, nextRandom(), resp);
    compareResp("register access", SmaSelectorPkg::SlvErr, resp);
    for (int i = 0; i < 4; i++) begin
      checkedRead("register access", selAddress(i), shadow[i], SmaSelectorPkg::Okay);
    end
    checkedRead("register access", `SMA_ADDR_VERSION, `SMA_VERSION, SmaSelectorPkg::Okay);
    checkedRead("register access", 16'h0100, 32'd0, SmaSelectorPkg::SlvErr);
  endtask

  task automatic checkOutputs(input logic [14:0] code, input logic [3:0] enables);
    logic [31:0] rnd;
    repeat (4) begin
      rnd      = nextRandom();
      sources  = rnd[12:0];
      ref10MHz = rnd[20];
      @(negedge SysClk_ClkIn);
      for (int k = 0; k < 4; k++) begin
        compareBit("output mux", expectedOut(code, k, sources, ref10MHz), smaOut[k]);
      end
      compareWord("output mux", {28'd0, enables}, {28'd0, smaOutEn});
    end
  endtask

  task automatic outputMuxTest();
    logic [14:0] code;
    logic [31:0] rnd;
    for (int idx = 0; idx < 16; idx++) begin
      code = (idx == 0) ? 15'd0 : (15'd1 << (idx - 1));
      rnd  = nextRandom();
      writeSelects("output mux", 1'b1, {4{code}}, rnd[3:0]);
      checkOutputs(code, rnd[3:0]);
    end
    // Two bits set is not a valid source
    rnd = nextRandom();
    writeSelects("output mux", 1'b1, {4{15'd3}}, rnd[3:0]);
    checkOutputs(15'd3, rnd[3:0]);
  endtask

  task automatic inputDemuxTest();
    logic [3:0][14:0] codes;
    logic [3:0]       enables;
    logic [31:0]      rnd;
    for (int cfgIdx = 0; cfgIdx < 4; cfgIdx++) begin
      if (cfgIdx == 0) begin
        // Overlapping selections, bits 7 and 9 to 11 left unselected
        codes = {15'h0150, 15'h1032, 15'h000F, 15'h0005};
      end else begin
        for (int k = 0; k < 4; k++) begin
          rnd = nextRandom();
          codes[k] = rnd[14:0] & rnd[29:15];
        end
      end
      rnd     = nextRandom();
      enables = rnd[3:0];
      writeSelects("input demux", 1'b0, codes, enables);
      repeat (4) begin
        rnd   = nextRandom();
        smaIn = rnd[3:0];
        @(negedge SysClk_ClkIn);
        compareWord("input demux", {19'd0, expectedDests(codes, smaIn)}, {19'd0, dests});
        compareWord("input demux", {28'd0, enables}, {28'd0, smaInEn});
      end
    end
  endtask

  task automatic statusTest();
    logic [3:0][14:0] codes;
    logic [31:0]      rnd;
    logic [31:0]      expected;
    repeat (3) begin
      rnd   = nextRandom();
      codes = {4{rnd[30:16]}};
      writeSelects("status", 1'b0, codes, rnd[3:0]);
      smaIn = rnd[7:4];
      // Status samples one cycle behind the pins
      repeat (2) @(negedge SysClk_ClkIn);
      expected = '0;
      for (int k = 0; k < 4; k++) begin
        expected[4*k]   = rnd[k];
        expected[4*k+1] = smaIn[k];
      end
      checkedRead("status", `SMA_ADDR_STATUS, expected & `SMA_STATUS_MASK,
                  SmaSelectorPkg::Okay);
    end
    writeSelects("status", 1'b0, {15'h0010, 15'h0008, 15'h0002, 15'h0000}, 4'hF);
    compareBit("status", 1'b1, ref10MHzEn);
    writeSelects("status", 1'b0, {15'h0010, 15'h0008, 15'h0002, 15'h0004}, 4'hF);
    compareBit("status", 1'b0, ref10MHzEn);
  endtask

  task automatic holdResponse(input logic [15:0] addr, input logic [31:0] data,
                              input SmaSelectorPkg::AxiResp_t expResp);
    bit                       accepted;
    SmaSelectorPkg::AxiResp_t resp;
    writeRequest(addr, data, accepted);
    if (accepted) begin
      compareResp("back-pressure", expResp, axiRsp.BResp);
      // A pending read must not be taken while the response waits
      axiReq.ArAddr  = `SMA_ADDR_VERSION;
      axiReq.ArValid = 1'b1;
      repeat (6) begin
        @(negedge SysClk_ClkIn);
        compareBit("back-pressure", 1'b1, axiRsp.BValid);
        compareResp("back-pressure", expResp, axiRsp.BResp);
        compareBit("back-pressure", 1'b0, axiRsp.ArReady);
      end
      axiReq.ArValid = 1'b0;
      writeResponse(resp);
      compareResp("back-pressure", expResp, resp);
      compareBit("back-pressure", 1'b0, axiRsp.BValid);
    end
  endtask

  task automatic backPressureTest();
    logic [31:0] data;
    data = nextRandom();
    holdResponse(`SMA_ADDR_IN_SEL34, data, SmaSelectorPkg::Okay);
    holdResponse(`SMA_ADDR_VERSION, nextRandom(), SmaSelectorPkg::SlvErr);
    checkedRead("back-pressure", `SMA_ADDR_IN_SEL34, data, SmaSelectorPkg::Okay);
  endtask

  // **************************************************
  // Main sequence
  // **************************************************

  initial begin
    rngState      = 32'h3d58_8aab;
    errorCount    = 0;
    checkCount    = 0;
    SysClk_ClkIn  = 1'b0;
    SysRstN_RstIn = 1'b1;
    axiReq        = '0;
    smaIn         = '0;
    sources       = '0;
    ref10MHz      = 1'b0;
    repeat (ResetCycles) @(negedge SysClk_ClkIn);
    SysRstN_RstIn = 1'b0;
    repeat (2) @(negedge SysClk_ClkIn);

    resetDefaultsTest();
    registerAccessTest();
    outputMuxTest();
    inputDemuxTest();
    statusTest();
    backPressureTest();

    $display("Checks run: %0d, errors: %0d", checkCount, errorCount);
    if (errorCount == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* SmaSelector.f */
+incdir+source
source/SmaSelectorPkg.sv
source/SmaRegBank.sv
source/SmaInputDemux.sv
source/SmaOutputMux.sv
source/SmaSelector.sv
tb/SmaSelectorTb.sv

/* Makefile */
# Verilator build and run of the SMA selector testbench

SOURCES := SmaSelector.f source/SmaSelector_cfg.svh $(wildcard source/*.sv) tb/SmaSelectorTb.sv

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
obj_dir/VSmaSelectorTb: $(SOURCES)
	verilator --binary --timing --timescale 1ns/1ps --top-module SmaSelectorTb \
		-f SmaSelector.f -o VSmaSelectorTb

# The run fails unless the log holds the pass line
run: obj_dir/VSmaSelectorTb
	obj_dir/VSmaSelectorTb | tee sim.log
	grep -q "^Test completed successfully$$" sim.log

clean:
	rm -rf obj_dir sim.log
